//--- Makefile
# Verilator flow for the cl_sort_shell testbench
TOP = tb_cl_sort_shell

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o V$(TOP)

run: build
	-./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@grep -qx "sim passed" sim.log

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- source/cl_sort_shell.sv
// Top level that connects the read-burst responder, the LED mask and the debug counter
`timescale 1ns/1ns

module cl_sort_shell #(
  parameter int DATA_W = f1_bus_pkg::DMA_DATA_W
) (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  // ------------------------------------------------------------------------
  // DMA read channel and upstream stream
  // ------------------------------------------------------------------------
  input  logic                    arvalid,
  input  f1_bus_pkg::dma_addr_t   araddr,
  input  f1_bus_pkg::beat_len_t   arlen,
  output logic                    arready,
  output logic                    rvalid,
  output logic [DATA_W-1:0]       rdata,
  output logic                    rlast,
  input  logic                    rready,
  input  logic                    in_valid,
  input  logic [DATA_W-1:0]       in_data,
  output logic                    in_ready,
  // Virtual LEDs and DIP switches
  input  f1_status_pkg::led_t     led_in,
  input  f1_status_pkg::dip_t     dip_in,
  output f1_status_pkg::led_t     vled,
  // Debug counter controls and status
  input  logic                    cnt_enable,
  input  logic                    cnt_load,
  input  logic                    cnt_clear,
  input  logic                    cnt_oneshot,
  input  f1_status_pkg::tick_t    tick_value,
  input  f1_status_pkg::count_t   load_value,
  input  f1_status_pkg::count_t   watermark,
  output logic                    tick,
  output logic                    cnt_ge_watermark,
  output f1_status_pkg::count_t   count
);

  // Burst responder, data width set here
  dma_read_burst #(
    .DATA_W (DATA_W)
  ) dma_read_burst_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arlen           (arlen),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rlast           (rlast),
    .rready          (rready),
    .in_valid        (in_valid),
    .in_data         (in_data),
    .in_ready        (in_ready)
  );

  vled_mask vled_mask_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .led_in          (led_in),
    .dip_in          (dip_in),
    .vled            (vled)
  );

  // Controls come straight from top-level pins
  tick_counter tick_counter_i (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .cnt_enable       (cnt_enable),
    .cnt_load         (cnt_load),
    .cnt_clear        (cnt_clear),
    .cnt_oneshot      (cnt_oneshot),
    .tick_value       (tick_value),
    .load_value       (load_value),
    .watermark        (watermark),
    .tick             (tick),
    .cnt_ge_watermark (cnt_ge_watermark),
    .count            (count)
  );

endmodule

//--- source/dma_read_burst.sv
// Read-burst responder, gates an upstream stream onto the AXI read data channel per accepted arlen
`timescale 1ns/1ns

module dma_read_burst #(
  parameter int DATA_W = f1_bus_pkg::DMA_DATA_W
) (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  // Read address channel
  input  logic                  arvalid,
  input  f1_bus_pkg::dma_addr_t araddr,
  input  f1_bus_pkg::beat_len_t arlen,
  output logic                  arready,
  // Read data channel
  output logic                  rvalid,
  output logic [DATA_W-1:0]     rdata,
  output logic                  rlast,
  input  logic                  rready,
  // Upstream stream
  input  logic                  in_valid,
  input  logic [DATA_W-1:0]     in_data,
  output logic                  in_ready
);

  import f1_bus_pkg::*;

  // --------------------------------------------------------------------------
  // Burst state
  // --------------------------------------------------------------------------

  // High from the cycle after the address handshake until the rlast beat
  logic      active;
  // Length captured from arlen, final beat index
  beat_len_t len_q;
  // Index of the beat currently offered on the read channel
  beat_len_t beat_idx;

  logic ar_fire;
  logic r_fire;

  // Only one burst outstanding at a time
  assign arready = ~active;

  assign ar_fire = arvalid & arready;
  assign r_fire  = rvalid & rready;

  // Address is taken with the burst but plays no part in the response
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      active   <= 1'b0;
      len_q    <= '0;
      beat_idx <= '0;
    end else if (ar_fire) begin
      active   <= 1'b1;
      len_q    <= arlen;
      beat_idx <= '0;
    end else if (r_fire) begin
      if (rlast) begin
        // Last beat gone, reopen the address channel next cycle
        active <= 1'b0;
      end else begin
        beat_idx <= beat_idx + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Data path
  // --------------------------------------------------------------------------

  // Zero-latency pass of the upstream stream while a burst is open
  assign rvalid   = active & in_valid;
  assign rdata    = in_data;
  assign rlast    = (beat_idx == len_q);

  // Upstream only pops on an accepted beat, so stalls hold data at the source
  assign in_ready = active & rready;

endmodule

//--- source/f1_bus_pkg.sv
// DMA read-channel widths and burst types, imported by the burst responder and the top level
package f1_bus_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------

  // Default read-data width, top level passes it down as DATA_W
  localparam int DMA_DATA_W = 64;

  // AXI arlen field width
  localparam int BEAT_LEN_W = 8;

  // Full host address width
  localparam int DMA_ADDR_W = 64;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  // Burst length as taken from arlen, also used as the beat index
  typedef logic [BEAT_LEN_W-1:0] beat_len_t;

  // Read address, accepted with the burst but never decoded
  typedef logic [DMA_ADDR_W-1:0] dma_addr_t;

endpackage

//--- source/f1_status_pkg.sv
// Status-side widths and counter types, shared by the LED mask and the debug counter
package f1_status_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------

  localparam int LED_W   = 16;
  localparam int DIP_W   = 16;
  localparam int TICK_W  = 8;
  localparam int COUNT_W = 16;

  // Vectors for the virtual LEDs and DIP switches
  typedef logic [LED_W-1:0]   led_t;
  typedef logic [DIP_W-1:0]   dip_t;

  // Prescaler compare value and its running count
  typedef logic [TICK_W-1:0]  tick_t;

  // Main count, load value and watermark share one width
  typedef logic [COUNT_W-1:0] count_t;

  // Saturation point for one-shot mode
  localparam count_t COUNT_MAX = '1;

  // Counter FSM, cnt_stop only reachable with one-shot set
  typedef enum logic [1:0] {
    cnt_idle,
    cnt_run,
    cnt_stop
  } cnt_state_e;

endpackage

//--- source/tick_counter.sv
// Debug counter with tick prescaler, load/clear/enable/one-shot controls and a watermark flag
`timescale 1ns/1ns

module tick_counter (
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  input  logic                  cnt_enable,
  input  logic                  cnt_load,
  input  logic                  cnt_clear,
  input  logic                  cnt_oneshot,
  input  f1_status_pkg::tick_t  tick_value,
  input  f1_status_pkg::count_t load_value,
  input  f1_status_pkg::count_t watermark,
  output logic                  tick,
  output logic                  cnt_ge_watermark,
  output f1_status_pkg::count_t count
);

  import f1_status_pkg::*;

  // --------------------------------------------------------------------------
  // Control input flops
  // --------------------------------------------------------------------------

  logic   enable_q;
  logic   load_q;
  logic   clear_q;
  logic   oneshot_q;
  tick_t  tick_value_q;
  count_t load_value_q;
  count_t watermark_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      enable_q     <= 1'b0;
      load_q       <= 1'b0;
      clear_q      <= 1'b0;
      oneshot_q    <= 1'b0;
      tick_value_q <= '0;
      load_value_q <= '0;
      watermark_q  <= '0;
    end else begin
      enable_q     <= cnt_enable;
      load_q       <= cnt_load;
      clear_q      <= cnt_clear;
      oneshot_q    <= cnt_oneshot;
      tick_value_q <= tick_value;
      load_value_q <= load_value;
      watermark_q  <= watermark;
    end
  end

  // --------------------------------------------------------------------------
  // Prescaler and main counter
  // --------------------------------------------------------------------------

  cnt_state_e state_q;
  cnt_state_e state_nxt;
  tick_t      tick_cnt_q;
  tick_t      tick_cnt_nxt;
  count_t     count_nxt;
  logic       tick_nxt;
  logic       tick_hit;

  // Compare with >= so a lowered tick_value still wraps promptly
  assign tick_hit = (tick_cnt_q >= tick_value_q);

  always_comb begin
    state_nxt    = state_q;
    tick_cnt_nxt = tick_cnt_q;
    count_nxt    = count;
    tick_nxt     = 1'b0;
    if (clear_q) begin
      tick_cnt_nxt = '0;
      count_nxt    = '0;
      state_nxt    = cnt_idle;
    end else if (load_q) begin
      count_nxt = load_value_q;
      state_nxt = cnt_run;
    end else if (enable_q) begin
      tick_cnt_nxt = tick_hit ? '0 : tick_cnt_q + 1'b1;
      tick_nxt     = tick_hit;
      // Stopped count only leaves on a clear or a load
      if (tick_hit && state_q != cnt_stop) begin
        if (oneshot_q) begin
          if (count != COUNT_MAX) count_nxt = count + 1'b1;
          state_nxt = (count_nxt == COUNT_MAX) ? cnt_stop : cnt_run;
        end else begin
          count_nxt = count + 1'b1;
          state_nxt = cnt_run;
        end
      end
    end
  end

  // Flag tracks the new count so both outputs agree on every cycle
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state_q          <= cnt_idle;
      tick_cnt_q       <= '0;
      count            <= '0;
      tick             <= 1'b0;
      cnt_ge_watermark <= 1'b0;
    end else begin
      state_q          <= state_nxt;
      tick_cnt_q       <= tick_cnt_nxt;
      count            <= count_nxt;
      tick             <= tick_nxt;
      cnt_ge_watermark <= (count_nxt >= watermark_q);
    end
  end

endmodule

//--- source/vled_mask.sv
// Virtual LED path, synchronizes the DIP switches and drives the LED value masked by them
`timescale 1ns/1ns

module vled_mask (
  input  logic                clk_main_a0,
  input  logic                rst_main_n_sync,
  input  f1_status_pkg::led_t led_in,
  input  f1_status_pkg::dip_t dip_in,
  output f1_status_pkg::led_t vled
);

  import f1_status_pkg::*;

  // Two-stage DIP synchronizer
  dip_t dip_q1;
  dip_t dip_q2;

  // LED value, one flop
  led_t led_q;

  // DIP switches arrive from another domain
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      dip_q1 <= '0;
      dip_q2 <= '0;
    end else begin
      dip_q1 <= dip_in;
      dip_q2 <= dip_q1;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      led_q <= '0;
    end else begin
      led_q <= led_in;
    end
  end

  // Output flop on the mask
  // led_in to vled is 2 cycles, dip_in to vled is 3
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled <= '0;
    end else begin
      vled <= led_q & dip_q2;
    end
  end

endmodule

//--- verif/cl_sort_cases.txt
# kind  a     b         c   d     e       all fields hex
# burst: len start stall beats last | led: led dip 0 0 vled | cnt: mode value cycles wmark count
burst 00 00001000 0 01 00001000
burst 03 00002000 0 04 00002003
burst 07 00003000 1 08 00003007
burst 0f 00004000 1 10 0000400f
burst 00 00006000 1 01 00006000
burst 1f 00005000 1 20 0000501f
burst ff 00007000 1 100 000070ff
burst 02 a5a50000 1 03 a5a50002
# led cases, dip set one cycle before led
led ffff ffff 0 0 ffff
led 00ff ff00 0 0 0000
led a5a5 0ff0 0 0 05a0
led 1234 ffff 0 0 1234
led ffff 8001 0 0 8001
led 0000 ffff 0 0 0000
# cnt mode bits: 1 enable, 2 one-shot, 4 load, 8 clear
cnt 4 1234 0 1000 1234
cnt 0 0000 5 1000 1234
cnt 1 0000 3 1240 1237
cnt 8 0000 0 0000 0000
cnt 5 0100 10 0105 0110
cnt 7 fffd 6 ffff ffff
cnt 0 0000 4 ffff ffff
cnt 3 0000 4 ffff ffff
cnt 5 fffd 6 0000 0003
cnt 5 ffff 1 8000 0000
cnt 9 0000 2 0000 0002
cnt 6 fff0 0 fff0 fff0
cnt 3 0000 20 fff0 ffff
cnt 8 0000 3 0001 0000

//--- verif/cl_sort_shell_sva.sv
// Read-channel and debug-counter assertions that are bound into every cl_sort_shell instance
`timescale 1ns/1ns

module cl_sort_shell_sva #(
  parameter int DATA_W = f1_bus_pkg::DMA_DATA_W
) (
  input logic                      clk_main_a0,
  input logic                      rst_main_n_sync,
  input logic                      arready,
  input logic                      rvalid,
  input logic                      rready,
  input logic [DATA_W-1:0]         rdata,
  input f1_status_pkg::count_t     count,
  input logic                      clear_q,
  input logic                      load_q,
  input f1_status_pkg::cnt_state_e state_q
);

  import f1_status_pkg::*;

  int fail_count = 0;

  // --------------------------------------------------------------------------
  // Read channel
  // --------------------------------------------------------------------------

  // Address channel only open between bursts
  a_ar_r_exclusive: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(arready && rvalid))
    else begin
      $error("arready and rvalid high together");
      fail_count++;
    end

  // Stalled beat keeps its data
  a_rdata_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> $stable(rdata))
    else begin
      $error("rdata changed under back-pressure");
      fail_count++;
    end

  // --------------------------------------------------------------------------
  // Counter
  // --------------------------------------------------------------------------

  // Wrap from the top is the only other way down
  a_count_no_drop: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(clear_q || load_q) |=> (count >= $past(count)) || ($past(count) == '1 && count == '0))
    else begin
      $error("count dropped without clear or load");
      fail_count++;
    end

  a_stop_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    state_q == cnt_stop && !clear_q && !load_q |=> $stable(count))
    else begin
      $error("count moved in the stop state");
      fail_count++;
    end

endmodule

bind cl_sort_shell cl_sort_shell_sva #(.DATA_W(DATA_W)) sva_i (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .arready         (arready),
  .rvalid          (rvalid),
  .rready          (rready),
  .rdata           (rdata),
  .count           (count),
  .clear_q         (tick_counter_i.clear_q),
  .load_q          (tick_counter_i.load_q),
  .state_q         (tick_counter_i.state_q)
);

//--- verif/tb_cl_sort_shell.sv
// Testbench for cl_sort_shell that runs the burst, LED and counter cases from the case file
`timescale 1ns/1ns

module tb_cl_sort_shell;

  import f1_bus_pkg::*;
  import f1_status_pkg::*;

  localparam int DATA_W     = DMA_DATA_W;
  localparam int MAX_CASES  = 64;
  localparam int KIND_BURST = 0;
  localparam int KIND_LED   = 1;
  localparam int KIND_CNT   = 2;

  // DUT ports
  logic              clk_main_a0;
  logic              rst_main_n_sync;
  logic              arvalid;
  dma_addr_t         araddr;
  beat_len_t         arlen;
  logic              arready;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic              rlast;
  logic              rready;
  logic              in_valid;
  logic [DATA_W-1:0] in_data;
  logic              in_ready;
  led_t              led_in;
  dip_t              dip_in;
  led_t              vled;
  logic              cnt_enable;
  logic              cnt_load;
  logic              cnt_clear;
  logic              cnt_oneshot;
  tick_t             tick_value;
  count_t            load_value;
  count_t            watermark;
  logic              tick;
  logic              cnt_ge_watermark;
  count_t            count;

  // Case table with one row per data line of the file
  int          kind_a  [MAX_CASES];
  logic [63:0] field_a [MAX_CASES];
  logic [63:0] field_b [MAX_CASES];
  logic [63:0] field_c [MAX_CASES];
  logic [63:0] field_d [MAX_CASES];
  logic [63:0] field_e [MAX_CASES];
  int          n_cases;

  int          err_count;
  int          case_errs;
  int          cases_passed;
  int          cycle_count;
  int          cycle_limit;
  logic        cases_loaded;
  logic        read_ok;
  integer      seed;

  cl_sort_shell #(.DATA_W(DATA_W)) cl_sort_shell_i (.*);

  initial begin
    clk_main_a0 = 1'b0;
    forever #50 clk_main_a0 = ~clk_main_a0;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_main_a0);
    #10;
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      err_count++;
      case_errs++;
    end
  endtask

  // Each line holds a kind and five hex fields
  // Lines that start with # are skipped
  task automatic load_cases(output logic ok);
    int               fd;
    int               code;
    logic             done;
    logic [8*8-1:0]   word;
    logic [8*160-1:0] rest;
    logic [63:0]      a, b, c, d, e;
    ok          = 1'b1;
    done        = 1'b0;
    n_cases     = 0;
    cycle_limit = 0;
    fd = $fopen("verif/cl_sort_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file verif/cl_sort_cases.txt");
      ok = 1'b0;
    end else begin
      while (ok && !done) begin
        code = $fscanf(fd, "%s", word);
        if (code != 1) begin
          done = 1'b1;
        end else if (word == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
          if (code != 5 || n_cases >= MAX_CASES ||
              !(word == "burst" || word == "led" || word == "cnt")) begin
            $display("malformed line in the case file after %0d cases", n_cases);
            ok = 1'b0;
          end else begin
            kind_a[n_cases]  = (word == "burst") ? KIND_BURST :
                               (word == "led") ? KIND_LED : KIND_CNT;
            field_a[n_cases] = a;
            field_b[n_cases] = b;
            field_c[n_cases] = c;
            field_d[n_cases] = d;
            field_e[n_cases] = e;
            // Budget grows with arlen for bursts and with the cycle count for counter runs
            cycle_limit += 4 * (int'((word == "burst") ? a : (word == "cnt") ? c : 0) + 1)
                           + 20;
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------------------------------------------------------------
  // Case runners
  // --------------------------------------------------------------------------

  // Upstream beat i carries start + i
  // rready stalls come from the seeded draw
  task automatic run_burst(input int idx, input logic [63:0] len, input logic [63:0] start,
                           input logic [63:0] stall, input logic [63:0] exp_beats,
                           input logic [63:0] exp_last);
    logic [31:0] rnd;
    logic [63:0] got;
    logic [63:0] last_data;
    logic        done;
    got       = '0;
    last_data = '0;
    done      = 1'b0;
    while (arready !== 1'b1) next_cycle();
    arvalid = 1'b1;
    arlen   = len[7:0];
    araddr  = start;
    next_cycle();
    arvalid = 1'b0;
    while (!done && got <= len) begin
      rnd      = $random(seed);
      in_valid = 1'b1;
      in_data  = start + got;
      rready   = (stall != 0) ? (rnd[1:0] != 2'b00) : 1'b1;
      // Outputs settled by the falling edge
      @(negedge clk_main_a0);
      check_value($sformatf("case %0d arready in burst", idx), 64'd0, arready);
      check_value($sformatf("case %0d rvalid", idx), 64'd1, rvalid);
      check_value($sformatf("case %0d in_ready", idx), rready, in_ready);
      if (rvalid && rready) begin
        check_value($sformatf("case %0d beat %0d data", idx, got), start + got, rdata);
        check_value($sformatf("case %0d beat %0d rlast", idx, got), got == len, rlast);
        last_data = rdata;
        done      = rlast;
        got       = got + 1;
      end
      next_cycle();
    end
    in_valid = 1'b0;
    rready   = 1'b0;
    check_value($sformatf("case %0d beat count", idx), exp_beats, got);
    check_value($sformatf("case %0d last data", idx), exp_last, last_data);
    check_value($sformatf("case %0d arready after burst", idx), 64'd1, arready);
  endtask

  // DIP set one cycle ahead of the LEDs so both latencies end on one edge
  task automatic run_led(input int idx, input logic [63:0] led, input logic [63:0] dip,
                         input logic [63:0] exp_vled);
    dip_in = dip[15:0];
    next_cycle();
    led_in = led[15:0];
    repeat (2) next_cycle();
    check_value($sformatf("case %0d vled", idx), exp_vled, vled);
  endtask

  // Mode bit 0 enables, bit 1 sets one-shot, bit 2 pulses load, bit 3 pulses clear
  task automatic run_count(input int idx, input logic [63:0] mode, input logic [63:0] value,
                           input logic [63:0] cycles, input logic [63:0] wmark,
                           input logic [63:0] expected);
    cnt_oneshot = mode[1];
    watermark   = wmark[15:0];
    tick_value  = '0;
    if (mode[2]) begin
      load_value = value[15:0];
      cnt_load   = 1'b1;
      next_cycle();
      cnt_load = 1'b0;
      next_cycle();
      check_value($sformatf("case %0d count after load", idx), value[15:0], count);
    end
    if (mode[3]) begin
      cnt_clear = 1'b1;
      next_cycle();
      cnt_clear = 1'b0;
      next_cycle();
      check_value($sformatf("case %0d count after clear", idx), 64'd0, count);
    end
    cnt_enable = mode[0];
    repeat (cycles) next_cycle();
    cnt_enable = 1'b0;
    // Last registered enable still acts one edge later
    next_cycle();
    // With tick_value 0 every enabled cycle ticks
    check_value($sformatf("case %0d tick", idx), mode[0] && cycles != 0, tick);
    next_cycle();
    check_value($sformatf("case %0d tick after enable drop", idx), 64'd0, tick);
    check_value($sformatf("case %0d count", idx), expected[15:0], count);
    check_value($sformatf("case %0d watermark flag", idx),
                expected[15:0] >= wmark[15:0], cnt_ge_watermark);
  endtask

  task automatic run_case(input int idx);
    case_errs = 0;
    case (kind_a[idx])
      KIND_BURST: run_burst(idx, field_a[idx], field_b[idx], field_c[idx], field_d[idx],
                            field_e[idx]);
      KIND_LED:   run_led(idx, field_a[idx], field_b[idx], field_e[idx]);
      default:    run_count(idx, field_a[idx], field_b[idx], field_c[idx], field_d[idx],
                            field_e[idx]);
    endcase
    if (case_errs == 0) cases_passed++;
    $display("case %0d (kind %0d): %s", idx, kind_a[idx], (case_errs == 0) ? "ok" : "FAILED");
  endtask

  // --------------------------------------------------------------------------
  // Run control
  // --------------------------------------------------------------------------

  initial begin
    wait (cases_loaded);
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk_main_a0);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("sim failed");
    $finish;
  end

  initial begin
    seed            = 32'h69fc_a86d;
    err_count       = 0;
    case_errs       = 0;
    cases_passed    = 0;
    cases_loaded    = 1'b0;
    rst_main_n_sync = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    arlen           = '0;
    rready          = 1'b0;
    in_valid        = 1'b0;
    in_data         = '0;
    led_in          = '0;
    dip_in          = '0;
    cnt_enable      = 1'b0;
    cnt_load        = 1'b0;
    cnt_clear       = 1'b0;
    cnt_oneshot     = 1'b0;
    tick_value      = '0;
    load_value      = '0;
    watermark       = '0;
    load_cases(read_ok);
    if (!read_ok) begin
      $display("case file could not be read, run stopped");
      $display("sim failed");
      $finish;
    end else begin
      cases_loaded = 1'b1;
      repeat (3) @(posedge clk_main_a0);
      #10;
      rst_main_n_sync = 1'b1;
      // Values straight out of reset
      check_value("reset arready", 64'd1, arready);
      check_value("reset rvalid", 64'd0, rvalid);
      check_value("reset vled", 64'd0, vled);
      check_value("reset count", 64'd0, count);
      for (int i = 0; i < n_cases; i++) run_case(i);
      if (cl_sort_shell_i.sva_i.fail_count != 0) begin
        $display("%0d assertion failures during the run", cl_sort_shell_i.sva_i.fail_count);
        err_count += cl_sort_shell_i.sva_i.fail_count;
      end
      $display("cases run %0d, passed %0d, failed %0d, errors %0d", n_cases, cases_passed,
               n_cases - cases_passed, err_count);
      if (err_count == 0) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end
  end

endmodule

//--- vlog.f
source/f1_bus_pkg.sv
source/f1_status_pkg.sv
source/dma_read_burst.sv
source/vled_mask.sv
source/tick_counter.sv
source/cl_sort_shell.sv
verif/cl_sort_shell_sva.sv
verif/tb_cl_sort_shell.sv
